// File: dv/arena_tb.sv
// arena testbench: LFSR-driven keys and buttons checked against a frame-level reference model
`timescale 1ns/100ps

module arena_tb;

    logic                         clk;
    logic                         rst_n;
    logic                         m_left1;
    logic                         m_right1;
    logic                         m_left2;
    logic                         m_right2;
    logic [1:0]                   button_pressed;
    logic                         cfg_we;
    logic [1:0]                   cfg_addr;
    logic [arena_pkg::xpos_w-1:0] cfg_wdata;
    logic                         frame_vsync;
    logic [arena_pkg::xpos_w-1:0] xpos_player1;
    logic [arena_pkg::xpos_w-1:0] xpos_player2;
    arena_pkg::player_state_t     state_player1;
    arena_pkg::player_state_t     state_player2;

    // reference model
    int                       m_cnt;       // cycle within the frame
    logic                     vs_prev;     // frame_vsync seen at the last edge
    logic                     m_open;
    logic                     m_restart;
    int                       m_lo;
    int                       m_hi;
    arena_pkg::player_state_t m_st1;
    arena_pkg::player_state_t m_st2;
    int                       m_x1;
    int                       m_x2;
    logic                     exp_vsync;

    logic [31:0] lfsr_state;

    arena_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .m_left1        (m_left1),
        .m_right1       (m_right1),
        .m_left2        (m_left2),
        .m_right2       (m_right2),
        .button_pressed (button_pressed),
        .cfg_we         (cfg_we),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .frame_vsync    (frame_vsync),
        .xpos_player1   (xpos_player1),
        .xpos_player2   (xpos_player2),
        .state_player1  (state_player1),
        .state_player2  (state_player2)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;   // 20 ns period
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        $display("Testbench failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // returns on the clock edge where the players act
    task automatic wait_frame_edge();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!(frame_vsync && !vs_prev)) begin
            waited++;
            if (waited > 2 * arena_pkg::frame_cycles) begin
                $display("no rising edge on frame_vsync within %0d cycles", waited);
                $display("Testbench failed");
                $fatal(1, "frame edge timeout");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_frames(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            wait_frame_edge();
        end
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [11:0] data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we    <= 1'b0;
    endtask

    task automatic release_inputs();
        @(posedge clk);
        m_left1        <= 1'b0;
        m_right1       <= 1'b0;
        m_left2        <= 1'b0;
        m_right2       <= 1'b0;
        button_pressed <= 2'b00;
    endtask

    task automatic check_players(input int x1, input int x2,
                                 input arena_pkg::player_state_t st1,
                                 input arena_pkg::player_state_t st2);
        @(negedge clk);
        expect_value("xpos_player1", 32'(xpos_player1), 32'(x1));
        expect_value("xpos_player2", 32'(xpos_player2), 32'(x2));
        expect_value("state_player1", 32'(state_player1), 32'(st1));
        expect_value("state_player2", 32'(state_player2), 32'(st2));
    endtask

    // restart pulse lands one cycle after the write and the players reset on the next
    task automatic restart_round();
        write_cfg(arena_pkg::reg_restart, 12'h000);
        repeat (2) @(posedge clk);
        check_players(0, int'(arena_pkg::x_max), arena_pkg::st_idle, arena_pkg::st_idle);
    endtask

    task automatic check_moved_gate(input int lo, input int hi);
        write_cfg(arena_pkg::reg_gate_lo, 12'(lo));
        write_cfg(arena_pkg::reg_gate_hi, 12'(hi));
        write_cfg(2'd3, 12'(lo - 3));   // would pull the gate left if decoded
        restart_round();
        @(posedge clk);
        m_right1 <= 1'b1;
        wait_frames(lo + 4);
        check_players(lo - 1, int'(arena_pkg::x_max), arena_pkg::st_right, arena_pkg::st_idle);
        @(posedge clk);
        button_pressed <= 2'b01;
        wait_frames(hi - lo + 4);   // one pixel per frame straight through
        check_players(hi + 3, int'(arena_pkg::x_max), arena_pkg::st_right, arena_pkg::st_idle);
    endtask

    // one frame of the movement rule for one player
    function automatic void apply_rule(
        input  arena_pkg::player_state_t st,
        input  int                       x,
        input  logic                     key_l,
        input  logic                     key_r,
        input  logic                     open,
        input  int                       lo,
        input  int                       hi,
        output arena_pkg::player_state_t st_new,
        output int                       x_new
    );
        int   target;
        logic key;
        st_new = st;
        x_new  = x;
        target = x;
        key    = 1'b0;
        case (st)
            arena_pkg::st_idle: begin
                if (key_r) st_new = arena_pkg::st_right;
                else if (key_l) st_new = arena_pkg::st_left;
            end
            arena_pkg::st_right: begin
                target = x + 1;
                key    = key_r;
                st_new = key_r ? arena_pkg::st_right : arena_pkg::st_idle;
            end
            arena_pkg::st_left: begin
                target = x - 1;   // may go to -1
                key    = key_l;
                st_new = key_l ? arena_pkg::st_left : arena_pkg::st_idle;
            end
            default: st_new = arena_pkg::st_idle;
        endcase
        if (key && target >= 0 && target <= int'(arena_pkg::x_max)
                && (target < lo || target > hi || open)) begin
            x_new = target;
        end
    endfunction

    always @(posedge clk) begin : ref_model
        arena_pkg::player_state_t st_n1;
        arena_pkg::player_state_t st_n2;
        int                       x_n1;
        int                       x_n2;
        logic                     new_frame;
        new_frame = frame_vsync && !vs_prev;
        apply_rule(m_st1, m_x1, m_left1, m_right1, m_open, m_lo, m_hi, st_n1, x_n1);
        apply_rule(m_st2, m_x2, m_left2, m_right2, m_open, m_lo, m_hi, st_n2, x_n2);
        if (!rst_n) begin
            m_cnt     <= 0;
            vs_prev   <= 1'b1;
            m_open    <= 1'b0;
            m_restart <= 1'b0;
            m_lo      <= int'(arena_pkg::gate_lo_rst);
            m_hi      <= int'(arena_pkg::gate_hi_rst);
            m_st1     <= arena_pkg::st_idle;
            m_st2     <= arena_pkg::st_idle;
            m_x1      <= 0;
            m_x2      <= int'(arena_pkg::x_max);
        end else begin
            m_cnt     <= (m_cnt == arena_pkg::frame_cycles - 1) ? 0 : m_cnt + 1;
            vs_prev   <= frame_vsync;
            m_open    <= |button_pressed;
            m_restart <= cfg_we && (cfg_addr == arena_pkg::reg_restart);
            if (cfg_we && cfg_addr == arena_pkg::reg_gate_lo) m_lo <= int'(cfg_wdata);
            if (cfg_we && cfg_addr == arena_pkg::reg_gate_hi) m_hi <= int'(cfg_wdata);
            if (m_restart) begin
                m_st1 <= arena_pkg::st_idle;
                m_st2 <= arena_pkg::st_idle;
                m_x1  <= 0;
                m_x2  <= int'(arena_pkg::x_max);
            end else if (new_frame) begin
                m_st1 <= st_n1;
                m_st2 <= st_n2;
                m_x1  <= x_n1;
                m_x2  <= x_n2;
            end
        end
    end

    assign exp_vsync = (m_cnt < arena_pkg::vsync_cycles);

    // outputs are settled at the falling edge
    vsync_matches: assert property (@(negedge clk) disable iff (!rst_n)
        frame_vsync == exp_vsync)
        else report_mismatch("frame_vsync", 32'(frame_vsync), 32'(exp_vsync));
    xpos1_matches: assert property (@(negedge clk) disable iff (!rst_n)
        32'(xpos_player1) == 32'(m_x1))
        else report_mismatch("xpos_player1", 32'(xpos_player1), 32'(m_x1));
    xpos2_matches: assert property (@(negedge clk) disable iff (!rst_n)
        32'(xpos_player2) == 32'(m_x2))
        else report_mismatch("xpos_player2", 32'(xpos_player2), 32'(m_x2));
    state1_matches: assert property (@(negedge clk) disable iff (!rst_n)
        state_player1 == m_st1)
        else report_mismatch("state_player1", 32'(state_player1), 32'(m_st1));
    state2_matches: assert property (@(negedge clk) disable iff (!rst_n)
        state_player2 == m_st2)
        else report_mismatch("state_player2", 32'(state_player2), 32'(m_st2));

    initial begin : stimulus
        logic [31:0] bits;
        int          f;
        int          k;
        lfsr_state = 32'h03aa_a354;
        rst_n          <= 1'b0;
        m_left1        <= 1'b0;
        m_right1       <= 1'b0;
        m_left2        <= 1'b0;
        m_right2       <= 1'b0;
        button_pressed <= 2'b00;
        cfg_we         <= 1'b0;
        cfg_addr       <= 2'd0;
        cfg_wdata      <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        check_players(0, int'(arena_pkg::x_max), arena_pkg::st_idle, arena_pkg::st_idle);
        wait_frames(3);

        // both players run into the closed gate
        @(posedge clk);
        m_right1 <= 1'b1;
        m_left2  <= 1'b1;
        wait_frames(1);
        check_players(0, int'(arena_pkg::x_max), arena_pkg::st_right, arena_pkg::st_left);
        wait_frames(429);
        check_players(int'(arena_pkg::gate_lo_rst) - 1, int'(arena_pkg::gate_hi_rst) + 1,
                      arena_pkg::st_right, arena_pkg::st_left);

        // player 2's button opens it for both
        @(posedge clk);
        button_pressed <= 2'b10;
        wait_frames(620);
        check_players(int'(arena_pkg::x_max), 0, arena_pkg::st_right, arena_pkg::st_left);

        release_inputs();
        wait_frames(1);
        check_players(int'(arena_pkg::x_max), 0, arena_pkg::st_idle, arena_pkg::st_idle);

        check_moved_gate(4, 8);

        // random keys around the moved gate and the right edge
        release_inputs();
        restart_round();
        for (f = 0; f < 400; f++) begin
            wait_frame_edge();
            take_bits(4, bits);
            m_left1  <= bits[0];
            m_right1 <= bits[1];
            m_left2  <= bits[2];
            m_right2 <= bits[3];
            take_bits(4, bits);
            button_pressed <= bits[1:0] & bits[3:2];
            take_bits(5, bits);
            k = int'(bits[4:0]);
            repeat (k + 1) @(posedge clk);   // buttons change mid-frame too
            take_bits(4, bits);
            button_pressed <= bits[1:0] & bits[3:2];
        end
        release_inputs();
        restart_round();

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: files.f
hdl/arena_pkg.sv
hdl/frame_timer.sv
hdl/gate_cfg_regs.sv
hdl/player_move_ctl.sv
hdl/arena_top.sv
dv/arena_tb.sv

// File: hdl/arena_pkg.sv
// arena package: shared sizes, limits, register map and player state encoding
package arena_pkg;

    // position word
    localparam int xpos_w = 12;

    // right screen edge, left edge is 0
    localparam logic [xpos_w-1:0] x_max = 12'd873;

    // gate bounds after reset, inclusive on both sides
    localparam logic [xpos_w-1:0] gate_lo_rst = 12'd425;
    localparam logic [xpos_w-1:0] gate_hi_rst = 12'd604;

    // frame timing in clock cycles
    // kept tiny so a sim run covers many frames
    localparam int frame_cycles = 24;
    localparam int vsync_cycles = 4;   // vsync high at the start of each frame

    // config register map, 2-bit address
    localparam logic [1:0] reg_gate_lo = 2'd0;
    localparam logic [1:0] reg_gate_hi = 2'd1;
    localparam logic [1:0] reg_restart = 2'd2;   // write-only strobe, data ignored
    // address 3 unused

    // per-player movement state
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_right = 2'd1,
        st_left  = 2'd2
    } player_state_t;

endpackage

// File: hdl/arena_top.sv
// arena motion core: frame timer, gate config and the two player controllers
`timescale 1ns/100ps

module arena_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          m_left1,
    input  logic                          m_right1,
    input  logic                          m_left2,
    input  logic                          m_right2,
    input  logic [1:0]                    button_pressed,
    input  logic                          cfg_we,
    input  logic [1:0]                    cfg_addr,
    input  logic [arena_pkg::xpos_w-1:0]  cfg_wdata,
    output logic                          frame_vsync,
    output logic [arena_pkg::xpos_w-1:0]  xpos_player1,
    output logic [arena_pkg::xpos_w-1:0]  xpos_player2,
    output arena_pkg::player_state_t      state_player1,
    output arena_pkg::player_state_t      state_player2
);

    logic                         vsync;
    logic [arena_pkg::xpos_w-1:0] gate_lo;
    logic [arena_pkg::xpos_w-1:0] gate_hi;
    logic                         gate_open;
    logic                         restart;

    frame_timer u_frame_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .vsync (vsync)
    );

    assign frame_vsync = vsync;

    gate_cfg_regs u_gate_cfg_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_we         (cfg_we),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .button_pressed (button_pressed),
        .gate_lo        (gate_lo),
        .gate_hi        (gate_hi),
        .gate_open      (gate_open),
        .restart        (restart)
    );

    // player 1 starts at the left edge
    player_move_ctl #(
        .START_X ('0)
    ) u_player1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .vsync     (vsync),
        .m_left    (m_left1),
        .m_right   (m_right1),
        .gate_open (gate_open),
        .restart   (restart),
        .gate_lo   (gate_lo),
        .gate_hi   (gate_hi),
        .xpos      (xpos_player1),
        .state     (state_player1)
    );

    // player 2 at the right edge
    player_move_ctl #(
        .START_X (arena_pkg::x_max)
    ) u_player2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .vsync     (vsync),
        .m_left    (m_left2),
        .m_right   (m_right2),
        .gate_open (gate_open),
        .restart   (restart),
        .gate_lo   (gate_lo),
        .gate_hi   (gate_hi),
        .xpos      (xpos_player2),
        .state     (state_player2)
    );

endmodule

// File: hdl/frame_timer.sv
// frame timer: free-running frame counter producing the vertical sync level
`timescale 1ns/100ps

module frame_timer (
    input  logic clk,
    input  logic rst_n,
    output logic vsync
);

    localparam int cnt_w = $clog2(arena_pkg::frame_cycles);

    logic [cnt_w-1:0] frame_cnt;
    logic [cnt_w-1:0] frame_cnt_nxt;
    logic             vsync_nxt;

    // wrap at the end of the frame
    always_comb begin
        if (frame_cnt == cnt_w'(arena_pkg::frame_cycles - 1)) begin
            frame_cnt_nxt = '0;
        end else begin
            frame_cnt_nxt = frame_cnt + 1'b1;
        end
    end

    // sync level follows the count it goes with
    assign vsync_nxt = (frame_cnt_nxt < cnt_w'(arena_pkg::vsync_cycles));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            vsync     <= 1'b1;   // count 0 is inside the sync window
        end else begin
            frame_cnt <= frame_cnt_nxt;
            vsync     <= vsync_nxt;
        end
    end

endmodule

// File: hdl/gate_cfg_regs.sv
// gate config registers: gate bounds, gate-open level and round restart strobe
`timescale 1ns/100ps

module gate_cfg_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_we,
    input  logic [1:0]                    cfg_addr,
    input  logic [arena_pkg::xpos_w-1:0]  cfg_wdata,
    input  logic [1:0]                    button_pressed,
    output logic [arena_pkg::xpos_w-1:0]  gate_lo,
    output logic [arena_pkg::xpos_w-1:0]  gate_hi,
    output logic                          gate_open,
    output logic                          restart
);

    logic wr_gate_lo;
    logic wr_gate_hi;
    logic wr_restart;

    // address decode
    always_comb begin
        wr_gate_lo = 1'b0;
        wr_gate_hi = 1'b0;
        wr_restart = 1'b0;
        if (cfg_we) begin
            case (cfg_addr)
                arena_pkg::reg_gate_lo: wr_gate_lo = 1'b1;
                arena_pkg::reg_gate_hi: wr_gate_hi = 1'b1;
                arena_pkg::reg_restart: wr_restart = 1'b1;
                default: ;   // addr 3 dropped
            endcase
        end
    end

    // bound registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gate_lo <= arena_pkg::gate_lo_rst;
            gate_hi <= arena_pkg::gate_hi_rst;
        end else begin
            if (wr_gate_lo) begin
                gate_lo <= cfg_wdata;
            end
            if (wr_gate_hi) begin
                gate_hi <= cfg_wdata;
            end
        end
    end

    // restart strobe lasts exactly one cycle per write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            restart <= 1'b0;
        end else begin
            restart <= wr_restart;
        end
    end

    // either player's button opens the gate for both
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gate_open <= 1'b0;
        end else begin
            gate_open <= |button_pressed;
        end
    end

endmodule

// File: hdl/player_move_ctl.sv
// player movement controller: steps the horizontal position once per frame
`timescale 1ns/100ps

module player_move_ctl #(
    parameter logic [arena_pkg::xpos_w-1:0] START_X = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          vsync,
    input  logic                          m_left,
    input  logic                          m_right,
    input  logic                          gate_open,
    input  logic                          restart,
    input  logic [arena_pkg::xpos_w-1:0]  gate_lo,
    input  logic [arena_pkg::xpos_w-1:0]  gate_hi,
    output logic [arena_pkg::xpos_w-1:0]  xpos,
    output arena_pkg::player_state_t      state
);

    arena_pkg::player_state_t     state_nxt;
    logic [arena_pkg::xpos_w-1:0] xpos_nxt;
    logic [arena_pkg::xpos_w-1:0] target;
    logic                         key_held;
    logic                         on_screen;
    logic                         in_gate;
    logic                         move_ok;
    logic                         vsync_q;
    logic                         frame_edge;

    // vsync edge detect
    // starts high so leaving reset is not taken as a new frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vsync_q <= 1'b1;
        end else begin
            vsync_q <= vsync;
        end
    end

    assign frame_edge = vsync && !vsync_q;

    // state and position only move on the frame edge
    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            state <= arena_pkg::st_idle;
            xpos  <= START_X;
        end else if (frame_edge) begin
            state <= state_nxt;
            xpos  <= xpos_nxt;
        end
    end

    // state decode: direction of travel and the key that keeps it going
    always_comb begin
        state_nxt = state;
        target    = xpos;
        key_held  = 1'b0;
        case (state)
            arena_pkg::st_idle: begin
                if (m_right) begin
                    state_nxt = arena_pkg::st_right;
                end else if (m_left) begin
                    state_nxt = arena_pkg::st_left;
                end
            end
            arena_pkg::st_right: begin
                target   = xpos + 1'b1;
                key_held = m_right;
                if (!m_right) begin
                    state_nxt = arena_pkg::st_idle;
                end
            end
            arena_pkg::st_left: begin
                target   = xpos - 1'b1;   // wraps below 0, caught by the screen check
                key_held = m_left;
                if (!m_left) begin
                    state_nxt = arena_pkg::st_idle;
                end
            end
            default: begin
                state_nxt = arena_pkg::st_idle;
            end
        endcase
    end

    // limits on the step
    assign on_screen = (target <= arena_pkg::x_max);
    assign in_gate   = (target >= gate_lo) && (target <= gate_hi);
    assign move_ok   = key_held && on_screen && (!in_gate || gate_open);

    // idle never moves since key_held stays low there
    assign xpos_nxt = move_ok ? target : xpos;

endmodule

// File: run.sh
#!/bin/sh
# build the arena testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f files.f --top-module arena_tb \
    && ./obj_dir/Varena_tb | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

exit 0
